// ==== cbuf_config.svh ====
// buffer sizes; the read tree is built for exactly 16 banks in 3 levels of fan-in 4
`ifndef CBUF_CONFIG_SVH
`define CBUF_CONFIG_SVH

// ========================================
// bank organisation
// ========================================

// one 1R1W RAM per bank
`define CBUF_BANK_NUM        16
// upper address bits pick the bank
`define CBUF_BANK_BITS       4

// ========================================
// RAM geometry
// ========================================

`define CBUF_RAM_DEPTH       64
// lower address bits pick the word
`define CBUF_RAM_DEPTH_BITS  6
// bank bits plus word bits
`define CBUF_ADDR_WIDTH      10
`define CBUF_DATA_WIDTH      64

// ========================================
// read path
// ========================================

// banks merged per OR-tree level, 16 -> 4 -> 1
`define CBUF_TREE_FANIN      4
// ctrl reg + RAM reg + 3 tree levels
`define CBUF_RD_LATENCY      5

`endif

// ==== cbuf_pkg.sv ====
// buffer types and address decode helpers; address layout is {bank, word} with no gaps
`include "cbuf_config.svh"

package cbuf_pkg;

  // full buffer address, {bank, word}
  typedef logic [`CBUF_ADDR_WIDTH-1:0]     cbuf_addr_t;
  typedef logic [`CBUF_DATA_WIDTH-1:0]     cbuf_word_t;
  typedef logic [`CBUF_BANK_BITS-1:0]      bank_idx_t;
  typedef logic [`CBUF_RAM_DEPTH_BITS-1:0] ram_addr_t;
  // one flag per bank
  typedef logic [`CBUF_BANK_NUM-1:0]       bank_vec_t;

  // bank field, upper bits
  function automatic bank_idx_t addr_bank(input cbuf_addr_t addr);
    return addr[`CBUF_ADDR_WIDTH-1 -: `CBUF_BANK_BITS];
  endfunction

  // word field, lower bits
  function automatic ram_addr_t addr_word(input cbuf_addr_t addr);
    return addr[`CBUF_RAM_DEPTH_BITS-1:0];
  endfunction

  // compare bank field with every bank number, gated by the strobe
  function automatic bank_vec_t bank_decode(input logic en, input cbuf_addr_t addr);
    bank_vec_t sel;
    for (int b = 0; b < `CBUF_BANK_NUM; b++) begin
      sel[b] = en && (addr_bank(addr) == bank_idx_t'(b));
    end
    return sel;
  endfunction

endpackage

// ==== cbuf_bank_ram.sv ====
// behavioral 1R1W bank RAM; read during write to the same word returns the old word
`include "cbuf_config.svh"

module cbuf_bank_ram
  import cbuf_pkg::*;
(
  input  logic       nvdla_core_clk,
  // read side
  input  logic       rd_en,
  input  ram_addr_t  rd_addr,
  // write side
  input  logic       wr_en,
  input  ram_addr_t  wr_addr,
  input  cbuf_word_t wr_data,
  // registered read data, holds between reads
  output cbuf_word_t rd_data
);

  // storage, contents unknown until written
  cbuf_word_t mem [`CBUF_RAM_DEPTH];

  // write port
  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, output register loads only on a read
  // stale data is masked later by the owner flags
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== cbuf_wr_ctrl.sv ====
// two write ports to 16 banks, 2 register stages; both ports hitting one bank in a cycle is not handled
`include "cbuf_config.svh"

module cbuf_wr_ctrl
  import cbuf_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       arst_n,
  // port 0, feature data
  input  logic       wr_en0,
  input  cbuf_addr_t wr_addr0,
  input  cbuf_word_t wr_data0,
  // port 1, weights
  input  logic       wr_en1,
  input  cbuf_addr_t wr_addr1,
  input  cbuf_word_t wr_data1,
  // per-bank RAM write controls
  output bank_vec_t  bank_wr_en,
  output ram_addr_t  bank_wr_addr [`CBUF_BANK_NUM],
  output cbuf_word_t bank_wr_data [`CBUF_BANK_NUM]
);

  // ========================================
  // stage 1: decode and register per port
  // ========================================

  bank_vec_t  wr0_sel;
  bank_vec_t  wr1_sel;
  bank_vec_t  wr0_sel_d1;
  bank_vec_t  wr1_sel_d1;
  ram_addr_t  wr_addr0_d1;
  ram_addr_t  wr_addr1_d1;
  cbuf_word_t wr_data0_d1;
  cbuf_word_t wr_data1_d1;

  // one-hot bank strobe per port
  assign wr0_sel = bank_decode(wr_en0, wr_addr0);
  assign wr1_sel = bank_decode(wr_en1, wr_addr1);

  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr0_sel_d1 <= '0;
      wr1_sel_d1 <= '0;
    end else begin
      wr0_sel_d1 <= wr0_sel;
      wr1_sel_d1 <= wr1_sel;
    end
  end

  // only the word field travels on, the bank is in the strobe now
  always_ff @(posedge nvdla_core_clk) begin
    wr_addr0_d1 <= addr_word(wr_addr0);
    wr_addr1_d1 <= addr_word(wr_addr1);
    wr_data0_d1 <= wr_data0;
    wr_data1_d1 <= wr_data1;
  end

  // ========================================
  // stage 2: per-bank select and register
  // ========================================

  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      bank_wr_en <= '0;
    end else begin
      bank_wr_en <= wr0_sel_d1 | wr1_sel_d1;
    end
  end

  // AND-OR pick of whichever port targets the bank
  // zero when neither does, RAM ignores it without the strobe
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < `CBUF_BANK_NUM; b++) begin
      bank_wr_addr[b] <= ({`CBUF_RAM_DEPTH_BITS{wr0_sel_d1[b]}} & wr_addr0_d1) |
                         ({`CBUF_RAM_DEPTH_BITS{wr1_sel_d1[b]}} & wr_addr1_d1);
      bank_wr_data[b] <= ({`CBUF_DATA_WIDTH{wr0_sel_d1[b]}} & wr_data0_d1) |
                         ({`CBUF_DATA_WIDTH{wr1_sel_d1[b]}} & wr_data1_d1);
    end
  end

endmodule

// ==== cbuf_rd_ctrl.sv ====
// data and weight reads to per-bank RAM reads; both clients on one bank in a cycle is not handled
`include "cbuf_config.svh"

module cbuf_rd_ctrl
  import cbuf_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       arst_n,
  // data read client
  input  logic       dat_rd_en,
  input  cbuf_addr_t dat_rd_addr,
  // weight read client
  input  logic       wt_rd_en,
  input  cbuf_addr_t wt_rd_addr,
  // per-bank RAM read controls
  output bank_vec_t  bank_rd_en,
  output ram_addr_t  bank_rd_addr [`CBUF_BANK_NUM],
  // owner flags, aligned with RAM output data
  output bank_vec_t  dat_own,
  output bank_vec_t  wt_own
);

  // ========================================
  // decode
  // ========================================

  bank_vec_t dat_sel;
  bank_vec_t wt_sel;
  ram_addr_t dat_word;
  ram_addr_t wt_word;
  bank_vec_t dat_own_d1;
  bank_vec_t wt_own_d1;

  assign dat_sel  = bank_decode(dat_rd_en, dat_rd_addr);
  assign wt_sel   = bank_decode(wt_rd_en, wt_rd_addr);
  assign dat_word = addr_word(dat_rd_addr);
  assign wt_word  = addr_word(wt_rd_addr);

  // ========================================
  // RAM read controls, 1 cycle
  // ========================================

  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      bank_rd_en <= '0;
    end else begin
      // clients are on different banks, so a plain OR merges them
      bank_rd_en <= dat_sel | wt_sel;
    end
  end

  // word address of whichever client owns the bank
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < `CBUF_BANK_NUM; b++) begin
      bank_rd_addr[b] <= ({`CBUF_RAM_DEPTH_BITS{dat_sel[b]}} & dat_word) |
                         ({`CBUF_RAM_DEPTH_BITS{wt_sel[b]}} & wt_word);
    end
  end

  // ========================================
  // owner tracking, 2 cycles
  // ========================================

  // first stage lines up with the RAM read strobe
  // second stage lines up with the RAM read data
  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      dat_own_d1 <= '0;
      wt_own_d1  <= '0;
      dat_own    <= '0;
      wt_own     <= '0;
    end else begin
      dat_own_d1 <= dat_sel;
      wt_own_d1  <= wt_sel;
      dat_own    <= dat_own_d1;
      wt_own     <= wt_own_d1;
    end
  end

endmodule

// ==== cbuf_rd_tree.sv ====
// masked OR-tree for one read client; assumes at most one owned bank per cycle and 16 banks
`include "cbuf_config.svh"

module cbuf_rd_tree
  import cbuf_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       arst_n,
  // banks owned by this client, aligned with RAM data
  input  bank_vec_t  own,
  input  cbuf_word_t bank_rd_data [`CBUF_BANK_NUM],
  output logic       rd_valid,
  output cbuf_word_t rd_data
);

  // groups after the first merge, 16 / 4
  localparam int L2_NUM = `CBUF_BANK_NUM / `CBUF_TREE_FANIN;
  // read latency minus ctrl reg and RAM reg
  localparam int VLD_STAGES = `CBUF_RD_LATENCY - 2;

  cbuf_word_t            l1_data   [`CBUF_BANK_NUM];
  cbuf_word_t            l2_data_w [L2_NUM];
  cbuf_word_t            l2_data   [L2_NUM];
  cbuf_word_t            l3_data_w;
  cbuf_word_t            l3_data;
  logic [VLD_STAGES-1:0] vld_pipe;

  // ========================================
  // level 1: mask and register each bank
  // ========================================

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < `CBUF_BANK_NUM; b++) begin
      l1_data[b] <= bank_rd_data[b] & {`CBUF_DATA_WIDTH{own[b]}};
    end
  end

  // ========================================
  // level 2: OR groups of four
  // ========================================

  always_comb begin
    for (int g = 0; g < L2_NUM; g++) begin
      l2_data_w[g] = '0;
      for (int k = 0; k < `CBUF_TREE_FANIN; k++) begin
        l2_data_w[g] = l2_data_w[g] | l1_data[g*`CBUF_TREE_FANIN + k];
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    l2_data <= l2_data_w;
  end

  // ========================================
  // level 3: OR the four groups
  // ========================================

  always_comb begin
    l3_data_w = '0;
    for (int g = 0; g < L2_NUM; g++) begin
      l3_data_w = l3_data_w | l2_data[g];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    l3_data <= l3_data_w;
  end

  assign rd_data = l3_data;

  // valid retimed alongside the three data levels
  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[VLD_STAGES-2:0], |own};
    end
  end

  assign rd_valid = vld_pipe[VLD_STAGES-1];

endmodule

// ==== cbuf.sv ====
// banked buffer top, 5-cycle reads; bank conflicts and read-after-write spacing are the caller's job
`include "cbuf_config.svh"

module cbuf
  import cbuf_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       arst_n,
  // write port 0, feature data
  input  logic       wr_en0,
  input  cbuf_addr_t wr_addr0,
  input  cbuf_word_t wr_data0,
  // write port 1, weights
  input  logic       wr_en1,
  input  cbuf_addr_t wr_addr1,
  input  cbuf_word_t wr_data1,
  // data read port
  input  logic       dat_rd_en,
  input  cbuf_addr_t dat_rd_addr,
  output logic       dat_rd_valid,
  output cbuf_word_t dat_rd_data,
  // weight read port
  input  logic       wt_rd_en,
  input  cbuf_addr_t wt_rd_addr,
  output logic       wt_rd_valid,
  output cbuf_word_t wt_rd_data
);

  // RAM write side
  bank_vec_t  bank_wr_en;
  ram_addr_t  bank_wr_addr [`CBUF_BANK_NUM];
  cbuf_word_t bank_wr_data [`CBUF_BANK_NUM];
  // RAM read side
  bank_vec_t  bank_rd_en;
  ram_addr_t  bank_rd_addr [`CBUF_BANK_NUM];
  cbuf_word_t bank_rd_data [`CBUF_BANK_NUM];
  // read owners, one vector per client
  bank_vec_t  dat_own;
  bank_vec_t  wt_own;

  // ========================================
  // write path
  // ========================================

  cbuf_wr_ctrl u_wr_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .wr_en0         (wr_en0),
    .wr_addr0       (wr_addr0),
    .wr_data0       (wr_data0),
    .wr_en1         (wr_en1),
    .wr_addr1       (wr_addr1),
    .wr_data1       (wr_data1),
    .bank_wr_en     (bank_wr_en),
    .bank_wr_addr   (bank_wr_addr),
    .bank_wr_data   (bank_wr_data)
  );

  // ========================================
  // read control
  // ========================================

  cbuf_rd_ctrl u_rd_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .dat_rd_en      (dat_rd_en),
    .dat_rd_addr    (dat_rd_addr),
    .wt_rd_en       (wt_rd_en),
    .wt_rd_addr     (wt_rd_addr),
    .bank_rd_en     (bank_rd_en),
    .bank_rd_addr   (bank_rd_addr),
    .dat_own        (dat_own),
    .wt_own         (wt_own)
  );

  // ========================================
  // bank RAMs
  // ========================================

  for (genvar b = 0; b < `CBUF_BANK_NUM; b++) begin : g_bank
    cbuf_bank_ram u_bank_ram (
      .nvdla_core_clk (nvdla_core_clk),
      .rd_en          (bank_rd_en[b]),
      .rd_addr        (bank_rd_addr[b]),
      .wr_en          (bank_wr_en[b]),
      .wr_addr        (bank_wr_addr[b]),
      .wr_data        (bank_wr_data[b]),
      .rd_data        (bank_rd_data[b])
    );
  end

  // ========================================
  // read trees, every bank feeds both
  // ========================================

  cbuf_rd_tree u_dat_tree (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .own            (dat_own),
    .bank_rd_data   (bank_rd_data),
    .rd_valid       (dat_rd_valid),
    .rd_data        (dat_rd_data)
  );

  cbuf_rd_tree u_wt_tree (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .own            (wt_own),
    .bank_rd_data   (bank_rd_data),
    .rd_valid       (wt_rd_valid),
    .rd_data        (wt_rd_data)
  );

endmodule

// ==== cbuf_sva.sv ====
// bound checker; compares both read ports against a shadow memory and checks bank conflicts
`include "cbuf_config.svh"

module cbuf_sva
  import cbuf_pkg::*;
(
  input logic       nvdla_core_clk,
  input logic       arst_n,
  input logic       wr_en0,
  input cbuf_addr_t wr_addr0,
  input cbuf_word_t wr_data0,
  input logic       wr_en1,
  input cbuf_addr_t wr_addr1,
  input cbuf_word_t wr_data1,
  input logic       dat_rd_en,
  input cbuf_addr_t dat_rd_addr,
  input logic       dat_rd_valid,
  input cbuf_word_t dat_rd_data,
  input logic       wt_rd_en,
  input cbuf_addr_t wt_rd_addr,
  input logic       wt_rd_valid,
  input cbuf_word_t wt_rd_data
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LAT = `CBUF_RD_LATENCY;

  // failed assertions so far, read by the testbench
  int err_cnt = 0;

  // whole buffer mirrored, indexed by full address
  cbuf_word_t shadow [1 << `CBUF_ADDR_WIDTH];
  // expected words in flight, oldest at the end
  cbuf_word_t exp_dat_q [LAT];
  cbuf_word_t exp_wt_q  [LAT];

  // ========================================
  // shadow memory and expected-word pipes
  // ========================================

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en0) begin
      shadow[wr_addr0] <= wr_data0;
    end
    if (wr_en1) begin
      shadow[wr_addr1] <= wr_data1;
    end
    // read sees the shadow before this edge's writes
    exp_dat_q[0] <= shadow[dat_rd_addr];
    exp_wt_q[0]  <= shadow[wt_rd_addr];
    for (int i = 1; i < LAT; i++) begin
      exp_dat_q[i] <= exp_dat_q[i-1];
      exp_wt_q[i]  <= exp_wt_q[i-1];
    end
  end

  // ========================================
  // input rules
  // ========================================

  a_wr_banks: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      wr_en0 && wr_en1 |-> addr_bank(wr_addr0) != addr_bank(wr_addr1))
    else begin
      err_cnt++;
      $error("both write ports hit the same bank in one cycle");
    end

  a_rd_banks: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      dat_rd_en && wt_rd_en |-> addr_bank(dat_rd_addr) != addr_bank(wt_rd_addr))
    else begin
      err_cnt++;
      $error("data and weight reads hit the same bank in one cycle");
    end

  // ========================================
  // latency, valid only 5 cycles after a read
  // ========================================

  a_dat_latency: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      dat_rd_valid == $past(dat_rd_en, LAT))
    else begin
      err_cnt++;
      $error("dat_rd_valid does not follow dat_rd_en by 5 cycles");
    end

  a_wt_latency: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      wt_rd_valid == $past(wt_rd_en, LAT))
    else begin
      err_cnt++;
      $error("wt_rd_valid does not follow wt_rd_en by 5 cycles");
    end

  // ========================================
  // read values
  // ========================================

  a_dat_value: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      dat_rd_valid |-> dat_rd_data === exp_dat_q[LAT-1])
    else begin
      err_cnt++;
      $error("mismatch dat_rd_data got %h exp %h",
             $sampled(dat_rd_data), $sampled(exp_dat_q[LAT-1]));
    end

  a_wt_value: assert property (@(posedge nvdla_core_clk) disable iff (!arst_n)
      wt_rd_valid |-> wt_rd_data === exp_wt_q[LAT-1])
    else begin
      err_cnt++;
      $error("mismatch wt_rd_data got %h exp %h",
             $sampled(wt_rd_data), $sampled(exp_wt_q[LAT-1]));
    end

endmodule

bind cbuf cbuf_sva u_sva (.*);

// ==== cbuf_tb.sv ====
// seeded random traffic for cbuf; all checking is done by the bound checker u_sva
`include "cbuf_config.svh"

module cbuf_tb
  import cbuf_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // cycle budget per test
  localparam int CYC_RESET = 30;
  localparam int CYC_WR_RD = 80;
  localparam int CYC_LAT   = 60;
  localparam int CYC_DUAL  = 40;
  localparam int CYC_PIPE  = 40;
  // whole run plus margin
  localparam int WATCHDOG_CYC = CYC_RESET + CYC_WR_RD + 2 * CYC_LAT + CYC_DUAL + CYC_PIPE + 100;

  logic       nvdla_core_clk = 1'b0;
  logic       arst_n;
  logic       wr_en0;
  cbuf_addr_t wr_addr0;
  cbuf_word_t wr_data0;
  logic       wr_en1;
  cbuf_addr_t wr_addr1;
  cbuf_word_t wr_data1;
  logic       dat_rd_en;
  cbuf_addr_t dat_rd_addr;
  logic       dat_rd_valid;
  cbuf_word_t dat_rd_data;
  logic       wt_rd_en;
  cbuf_addr_t wt_rd_addr;
  logic       wt_rd_valid;
  cbuf_word_t wt_rd_data;

  // last written address in each bank, reads pick from here
  cbuf_addr_t last_addr [`CBUF_BANK_NUM];
  int         test_cnt;
  int         err_start;

  // 10 ns clock
  always #5 nvdla_core_clk = ~nvdla_core_clk;

  cbuf u_cbuf (.*);

  // ========================================
  // helpers
  // ========================================

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge nvdla_core_clk);
    #1;
  endtask

  task automatic idle(input int n);
    wr_en0    = 1'b0;
    wr_en1    = 1'b0;
    dat_rd_en = 1'b0;
    wt_rd_en  = 1'b0;
    repeat (n) next_cycle();
  endtask

  function automatic cbuf_word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // random bank that differs from b, the add wraps mod 16
  function automatic bank_idx_t other_bank(input bank_idx_t b);
    return b + bank_idx_t'($urandom_range(15, 1));
  endfunction

  function automatic cbuf_addr_t rand_addr_in(input bank_idx_t b);
    return {b, ram_addr_t'($urandom_range(`CBUF_RAM_DEPTH - 1))};
  endfunction

  task automatic end_test(input string name);
    int errs;
    errs = u_cbuf.u_sva.err_cnt - err_start;
    test_cnt++;
    $display("test %-10s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    err_start = u_cbuf.u_sva.err_cnt;
  endtask

  // sparse reads on one port, gaps of 0 to 4 cycles
  task automatic sparse_reads(input bit wt_port);
    for (int i = 0; i < 8; i++) begin
      if (wt_port) begin
        wt_rd_en   = 1'b1;
        wt_rd_addr = last_addr[$urandom_range(`CBUF_BANK_NUM - 1)];
      end else begin
        dat_rd_en   = 1'b1;
        dat_rd_addr = last_addr[$urandom_range(`CBUF_BANK_NUM - 1)];
      end
      next_cycle();
      idle($urandom_range(4));
    end
    // drain the pipe
    idle(6);
  endtask

  // ========================================
  // tests
  // ========================================

  initial begin
    bank_idx_t b0;
    bank_idx_t b1;
    bank_idx_t dat_b [8];
    bank_idx_t wt_b  [8];
    void'($urandom(32094));
    arst_n      = 1'b0;
    wr_en0      = 1'b0;
    wr_addr0    = '0;
    wr_data0    = '0;
    wr_en1      = 1'b0;
    wr_addr1    = '0;
    wr_data1    = '0;
    dat_rd_en   = 1'b0;
    dat_rd_addr = '0;
    wt_rd_en    = 1'b0;
    wt_rd_addr  = '0;
    test_cnt    = 0;
    err_start   = 0;
    repeat (10) @(posedge nvdla_core_clk);
    #1;
    arst_n = 1'b1;

    // no reads, valids must stay low
    idle(12);
    end_test("reset");

    // port 0 fills every bank, then both ports read it back
    for (int b = 0; b < `CBUF_BANK_NUM; b++) begin
      last_addr[b] = rand_addr_in(bank_idx_t'(b));
      wr_en0       = 1'b1;
      wr_addr0     = last_addr[b];
      wr_data0     = rand_word();
      next_cycle();
    end
    idle(3);
    for (int b = 0; b < 2 * `CBUF_BANK_NUM; b++) begin
      dat_rd_en   = (b < `CBUF_BANK_NUM);
      wt_rd_en    = (b >= `CBUF_BANK_NUM);
      dat_rd_addr = last_addr[b % `CBUF_BANK_NUM];
      wt_rd_addr  = last_addr[b % `CBUF_BANK_NUM];
      next_cycle();
    end
    idle(6);
    end_test("wr_rd");

    sparse_reads(1'b0);
    end_test("dat_lat");
    sparse_reads(1'b1);
    end_test("wt_lat");

    // both write ports on different banks, then paired reads
    for (int i = 0; i < 8; i++) begin
      b0            = bank_idx_t'($urandom_range(`CBUF_BANK_NUM - 1));
      b1            = other_bank(b0);
      dat_b[i]      = b0;
      wt_b[i]       = b1;
      last_addr[b0] = rand_addr_in(b0);
      last_addr[b1] = rand_addr_in(b1);
      wr_en0        = 1'b1;
      wr_addr0      = last_addr[b0];
      wr_data0      = rand_word();
      wr_en1        = 1'b1;
      wr_addr1      = last_addr[b1];
      wr_data1      = rand_word();
      next_cycle();
    end
    idle(3);
    for (int i = 0; i < 8; i++) begin
      dat_rd_en   = 1'b1;
      dat_rd_addr = last_addr[dat_b[i]];
      wt_rd_en    = 1'b1;
      wt_rd_addr  = last_addr[wt_b[i]];
      next_cycle();
    end
    idle(6);
    end_test("dual");

    // back-to-back reads, five per port in flight
    for (int i = 0; i < 20; i++) begin
      b0          = bank_idx_t'($urandom_range(`CBUF_BANK_NUM - 1));
      b1          = other_bank(b0);
      dat_rd_en   = 1'b1;
      dat_rd_addr = last_addr[b0];
      wt_rd_en    = 1'b1;
      wt_rd_addr  = last_addr[b1];
      next_cycle();
    end
    idle(6);
    end_test("pipe");

    $display("tests %0d, errors %0d", test_cnt, u_cbuf.u_sva.err_cnt);
    if (u_cbuf.u_sva.err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYC * 10);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYC);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== cbuf.f ====
+incdir+.
cbuf_pkg.sv
cbuf_bank_ram.sv
cbuf_wr_ctrl.sv
cbuf_rd_ctrl.sv
cbuf_rd_tree.sv
cbuf.sv
cbuf_sva.sv
cbuf_tb.sv
